//--- hw/accessChecker.sv
module accessChecker #(
    parameter logic [memAccessPkg::DataWidth-1:0] DmLimit    = memAccessPkg::DefDmLimit,
    parameter logic [memAccessPkg::DataWidth-1:0] Timer0Base = memAccessPkg::DefTimer0Base,
    parameter logic [memAccessPkg::DataWidth-1:0] Timer1Base = memAccessPkg::DefTimer1Base,
    parameter logic [memAccessPkg::DataWidth-1:0] IntGenBase = memAccessPkg::DefIntGenBase
) (
    input  logic [memAccessPkg::DataWidth-1:0] addr,
    input  memAccessPkg::accessWidthT          width,
    input  logic                               write,
    output memAccessPkg::excCodeT              excCode
);

    // Window sizes in bytes
    localparam logic [memAccessPkg::DataWidth-1:0] TimerSpan  = 32'd12;
    localparam logic [memAccessPkg::DataWidth-1:0] IntGenSpan = 32'd4;

    logic [memAccessPkg::DataWidth-1:0] timer0Off;
    logic [memAccessPkg::DataWidth-1:0] timer1Off;
    logic inDm;
    logic inTimer0;
    logic inTimer1;
    logic inTimer;
    logic inIntGen;
    logic countReg;
    logic badAlign;
    logic badAccess;

    // Offsets wrap to large values below the base, so one compare suffices
    assign timer0Off = addr - Timer0Base;
    assign timer1Off = addr - Timer1Base;

    assign inDm     = addr < DmLimit;
    assign inTimer0 = timer0Off < TimerSpan;
    assign inTimer1 = timer1Off < TimerSpan;
    assign inTimer  = inTimer0 || inTimer1;
    assign inIntGen = (addr - IntGenBase) < IntGenSpan;

    // Word index 2 of a timer is its count register
    assign countReg = (inTimer0 && timer0Off[3:2] == 2'd2)
                   || (inTimer1 && timer1Off[3:2] == 2'd2);

    assign badAlign = (width == memAccessPkg::widthWord && addr[1:0] != 2'b00)
                   || (width == memAccessPkg::widthHalf && addr[0]);

    assign badAccess = badAlign
                    || (width != memAccessPkg::widthWord && inTimer)
                    || !(inDm || inTimer || inIntGen)
                    || (write && countReg);

    always_comb begin
        if (!badAccess) begin
            excCode = memAccessPkg::excNone;
        end else if (write) begin
            excCode = memAccessPkg::excAddrStore;
        end else begin
            excCode = memAccessPkg::excAddrLoad;
        end
    end

endmodule

//--- hw/accessSequencer.sv
module accessSequencer #(
    parameter logic [memAccessPkg::DataWidth-1:0] DmLimit    = memAccessPkg::DefDmLimit,
    parameter logic [memAccessPkg::DataWidth-1:0] Timer0Base = memAccessPkg::DefTimer0Base,
    parameter logic [memAccessPkg::DataWidth-1:0] Timer1Base = memAccessPkg::DefTimer1Base,
    parameter logic [memAccessPkg::DataWidth-1:0] IntGenBase = memAccessPkg::DefIntGenBase
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               req,
    output logic                               ack,
    input  logic [memAccessPkg::DataWidth-1:0] addr,
    input  memAccessPkg::accessWidthT          width,
    input  logic                               write,
    input  logic [memAccessPkg::DataWidth-1:0] wdata,
    output logic [memAccessPkg::DataWidth-1:0] rdata,
    output memAccessPkg::excCodeT              excCode,
    output logic [memAccessPkg::DataWidth-1:0] memAddr,
    output logic [memAccessPkg::DataWidth-1:0] memWdata,
    output logic [3:0]                         memByteen,
    input  logic [memAccessPkg::DataWidth-1:0] memRdata
);

    typedef enum logic [1:0] {
        stIdle,
        stIssue,
        stResponse,
        stAck
    } stateT;

    stateT state;

    // Request held for the whole access
    logic [memAccessPkg::DataWidth-1:0] addrReg;
    logic [memAccessPkg::DataWidth-1:0] wdataReg;
    memAccessPkg::accessWidthT          widthReg;
    logic                               writeReg;
    memAccessPkg::excCodeT              excReg;

    memAccessPkg::excCodeT              checkCode;
    logic [memAccessPkg::DataWidth-1:0] laneData;
    logic [3:0]                         laneEnable;
    logic [memAccessPkg::DataWidth-1:0] loadData;
    logic                               legal;
    logic                               accept;

    accessChecker #(
        .DmLimit    (DmLimit),
        .Timer0Base (Timer0Base),
        .Timer1Base (Timer1Base),
        .IntGenBase (IntGenBase)
    ) checker0 (
        .addr    (addr),
        .width   (width),
        .write   (write),
        .excCode (checkCode)
    );

    storeFormatter formatter0 (
        .addrLow    (addrReg[1:0]),
        .width      (widthReg),
        .wdata      (wdataReg),
        .laneData   (laneData),
        .laneEnable (laneEnable)
    );

    loadExtractor extractor0 (
        .addrLow  (addrReg[1:0]),
        .width    (widthReg),
        .memWord  (memRdata),
        .loadData (loadData)
    );

    assign accept = (state == stIdle) && req;
    assign legal  = (excReg == memAccessPkg::excNone);

    // Bus is live for the issue cycle only
    assign memAddr   = addrReg;
    assign memWdata  = laneData;
    assign memByteen = (state == stIssue && writeReg && legal) ? laneEnable : 4'b0000;
    assign ack       = (state == stAck);

    always_ff @(posedge clk) begin
        if (accept) begin
            addrReg  <= addr;
            widthReg <= width;
            writeReg <= write;
            wdataReg <= wdata;
            excReg   <= checkCode;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stIdle;
            rdata   <= '0;
            excCode <= memAccessPkg::excNone;
        end else begin
            case (state)
                stIdle: begin
                    if (req) begin
                        state <= stIssue;
                    end
                end
                stIssue: begin
                    state <= stResponse;
                end
                stResponse: begin
                    // Only a legal load returns data
                    rdata   <= (legal && !writeReg) ? loadData : '0;
                    excCode <= excReg;
                    state   <= stAck;
                end
                default: begin
                    // Hold ack until the requester lets go
                    if (!req) begin
                        state <= stIdle;
                    end
                end
            endcase
        end
    end

endmodule

//--- hw/loadExtractor.sv
module loadExtractor (
    input  logic [1:0]                         addrLow,
    input  memAccessPkg::accessWidthT          width,
    input  logic [memAccessPkg::DataWidth-1:0] memWord,
    output logic [memAccessPkg::DataWidth-1:0] loadData
);

    logic [15:0] halfLane;
    logic [7:0]  byteLane;

    // Lane select from the byte offset
    assign halfLane = addrLow[1] ? memWord[31:16] : memWord[15:0];

    always_comb begin
        case (addrLow)
            2'd0:    byteLane = memWord[7:0];
            2'd1:    byteLane = memWord[15:8];
            2'd2:    byteLane = memWord[23:16];
            default: byteLane = memWord[31:24];
        endcase
    end

    // Sign extension to a full word
    always_comb begin
        case (width)
            memAccessPkg::widthHalf: begin
                loadData = {{16{halfLane[15]}}, halfLane};
            end
            memAccessPkg::widthByte: begin
                loadData = {{24{byteLane[7]}}, byteLane};
            end
            default: begin
                loadData = memWord;
            end
        endcase
    end

endmodule

//--- hw/memAccessPkg.sv
package memAccessPkg;

    // Address and data word width
    parameter int DataWidth = 32;

    // Access size, same codes as the CPU's DM width field
    typedef enum logic [1:0] {
        widthWord = 2'd0,
        widthHalf = 2'd1,
        widthByte = 2'd2
    } accessWidthT;

    // CP0-style exception codes for data accesses
    typedef enum logic [4:0] {
        excNone      = 5'd0,
        excAddrLoad  = 5'd4,
        excAddrStore = 5'd5
    } excCodeT;

    // Default address map
    parameter logic [DataWidth-1:0] DefDmLimit    = 32'h0000_3000;
    parameter logic [DataWidth-1:0] DefTimer0Base = 32'h0000_7F00;
    parameter logic [DataWidth-1:0] DefTimer1Base = 32'h0000_7F10;
    parameter logic [DataWidth-1:0] DefIntGenBase = 32'h0000_7F20;

endpackage

//--- hw/memAccessTop.sv
module memAccessTop #(
    parameter logic [memAccessPkg::DataWidth-1:0] DmLimit    = memAccessPkg::DefDmLimit,
    parameter logic [memAccessPkg::DataWidth-1:0] Timer0Base = memAccessPkg::DefTimer0Base,
    parameter logic [memAccessPkg::DataWidth-1:0] Timer1Base = memAccessPkg::DefTimer1Base,
    parameter logic [memAccessPkg::DataWidth-1:0] IntGenBase = memAccessPkg::DefIntGenBase
) (
    input  logic                               clk,
    input  logic                               rst,

    // Requester side
    input  logic                               req,
    output logic                               ack,
    input  logic [memAccessPkg::DataWidth-1:0] addr,
    input  memAccessPkg::accessWidthT          width,
    input  logic                               write,
    input  logic [memAccessPkg::DataWidth-1:0] wdata,
    output logic [memAccessPkg::DataWidth-1:0] rdata,
    output memAccessPkg::excCodeT              excCode,

    // Data memory side
    output logic [memAccessPkg::DataWidth-1:0] memAddr,
    output logic [memAccessPkg::DataWidth-1:0] memWdata,
    output logic [3:0]                         memByteen,
    input  logic [memAccessPkg::DataWidth-1:0] memRdata
);

    // Address map goes down to the checker
    accessSequencer #(
        .DmLimit    (DmLimit),
        .Timer0Base (Timer0Base),
        .Timer1Base (Timer1Base),
        .IntGenBase (IntGenBase)
    ) sequencer0 (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .ack       (ack),
        .addr      (addr),
        .width     (width),
        .write     (write),
        .wdata     (wdata),
        .rdata     (rdata),
        .excCode   (excCode),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .memByteen (memByteen),
        .memRdata  (memRdata)
    );

endmodule

//--- hw/storeFormatter.sv
module storeFormatter (
    input  logic [1:0]                         addrLow,
    input  memAccessPkg::accessWidthT          width,
    input  logic [memAccessPkg::DataWidth-1:0] wdata,
    output logic [memAccessPkg::DataWidth-1:0] laneData,
    output logic [3:0]                         laneEnable
);

    // Lanes are replicated so the memory only needs the enables
    always_comb begin
        case (width)
            memAccessPkg::widthWord: begin
                laneData   = wdata;
                laneEnable = 4'b1111;
            end
            memAccessPkg::widthHalf: begin
                laneData = {2{wdata[15:0]}};
                if (addrLow[1]) begin
                    laneEnable = 4'b1100;
                end else begin
                    laneEnable = 4'b0011;
                end
            end
            memAccessPkg::widthByte: begin
                laneData   = {4{wdata[7:0]}};
                laneEnable = 4'b0001 << addrLow;
            end
            default: begin
                // Unused width code writes nothing
                laneData   = '0;
                laneEnable = 4'b0000;
            end
        endcase
    end

endmodule

//--- project.f
hw/memAccessPkg.sv
hw/accessChecker.sv
hw/storeFormatter.sv
hw/loadExtractor.sv
hw/accessSequencer.sv
hw/memAccessTop.sv
verif/memAccessTb_sva.sv
verif/memAccessTb.sv

//--- run.sh
#!/bin/sh
verilator --binary --assert --top-module memAccessTb -f project.f -o memAccessSim \
    && ./obj_dir/memAccessSim \
    || exit 1

//--- verif/memAccessTb.sv
module memAccessTb;

    localparam int WordPairs = 16;
    // Word pairs, then subword, misaligned, region and handshake accesses
    localparam int AccessCount = 2 * WordPairs + 18 + 15 + 18 + 3;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      req;
    logic                      ack;
    logic [31:0]               addr;
    memAccessPkg::accessWidthT width;
    logic                      write;
    logic [31:0]               wdata;
    logic [31:0]               rdata;
    memAccessPkg::excCodeT     excCode;
    logic [31:0]               memAddr;
    logic [31:0]               memWdata;
    logic [3:0]                memByteen;
    logic [31:0]               memRdata = '0;
    logic [31:0]               mem [0:4095];
    logic [31:0]               shadow [0:4095];
    integer                    seed = 39;

    memAccessTop dut0 (
        .clk(clk), .rst(rst), .req(req), .ack(ack),
        .addr(addr), .width(width), .write(write), .wdata(wdata),
        .rdata(rdata), .excCode(excCode),
        .memAddr(memAddr), .memWdata(memWdata), .memByteen(memByteen), .memRdata(memRdata)
    );

    bind memAccessTop memAccessTbSva sva0 (
        .clk(clk), .rst(rst), .req(req), .ack(ack), .write(write),
        .memByteen(memByteen), .excCode(excCode)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] fillWord(input logic [31:0] index);
        return (index * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    endfunction

    function automatic logic [31:0] laneMask(input logic [3:0] en);
        return {{8{en[3]}}, {8{en[2]}}, {8{en[1]}}, {8{en[0]}}};
    endfunction

    // Synchronous data memory with read-first ordering
    always @(posedge clk) begin
        memRdata <= mem[memAddr[13:2]];
        if (memByteen != 4'b0000) begin
            mem[memAddr[13:2]] = (mem[memAddr[13:2]] & ~laneMask(memByteen))
                               | (memWdata & laneMask(memByteen));
        end
    end

    function automatic logic [3:0] storeLanes(input logic [31:0] a,
                                              input memAccessPkg::accessWidthT w);
        case (w)
            memAccessPkg::widthByte: return 4'b0001 << a[1:0];
            memAccessPkg::widthHalf: return 4'b0011 << a[1:0];
            default:                 return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] loadValue(input logic [31:0] word, input logic [31:0] a,
                                              input memAccessPkg::accessWidthT w);
        logic [31:0] lane;
        lane = word >> {a[1:0], 3'b000};
        case (w)
            memAccessPkg::widthByte: return {{24{lane[7]}}, lane[7:0]};
            memAccessPkg::widthHalf: return {{16{lane[15]}}, lane[15:0]};
            default:                 return word;
        endcase
    endfunction

    function automatic logic inWindow(input logic [31:0] a, input logic [31:0] base,
                                      input logic [31:0] span);
        return (a >= base) && (a < base + span);
    endfunction

    // Reference rules for address exceptions
    function automatic memAccessPkg::excCodeT expectCode(input logic [31:0] a,
                                                         input memAccessPkg::accessWidthT w,
                                                         input logic wr);
        logic timer;
        logic mapped;
        logic aligned;
        logic countHit;
        timer = inWindow(a, memAccessPkg::DefTimer0Base, 32'd12)
             || inWindow(a, memAccessPkg::DefTimer1Base, 32'd12);
        mapped = (a < memAccessPkg::DefDmLimit) || timer
              || inWindow(a, memAccessPkg::DefIntGenBase, 32'd4);
        aligned = (w == memAccessPkg::widthWord) ? (a[1:0] == 2'b00)
                : ((w == memAccessPkg::widthHalf) ? !a[0] : 1'b1);
        countHit = inWindow(a, memAccessPkg::DefTimer0Base + 32'd8, 32'd4)
                || inWindow(a, memAccessPkg::DefTimer1Base + 32'd8, 32'd4);
        if (aligned && mapped && !(timer && w != memAccessPkg::widthWord) && !(wr && countHit))
            return memAccessPkg::excNone;
        else if (wr)
            return memAccessPkg::excAddrStore;
        else
            return memAccessPkg::excAddrLoad;
    endfunction

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s %s expected %h actual %h", testName, what, expected, actual);
            $display("Checks failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // One four-phase access checked against the shadow memory
    task automatic access(input string testName, input logic [31:0] a,
                          input memAccessPkg::accessWidthT w, input logic wr,
                          input logic [31:0] data, input int holdCycles);
        memAccessPkg::excCodeT expCode;
        logic [31:0]           expData;
        logic [31:0]           mask;
        logic [31:0]           gotData;
        memAccessPkg::excCodeT gotCode;
        expCode = expectCode(a, w, wr);
        expData = 32'd0;
        mask = laneMask(storeLanes(a, w));
        if (expCode == memAccessPkg::excNone && !wr)
            expData = loadValue(shadow[a[13:2]], a, w);
        if (expCode == memAccessPkg::excNone && wr)
            shadow[a[13:2]] = (shadow[a[13:2]] & ~mask) | ((data << {a[1:0], 3'b000}) & mask);
        req = 1'b1;
        addr = a;
        width = w;
        write = wr;
        wdata = data;
        @(posedge clk);
        #1;
        while (!ack) begin
            @(posedge clk);
            #1;
        end
        gotData = rdata;
        gotCode = excCode;
        checkValue(testName, "rdata", expData, gotData);
        checkValue(testName, "excCode", 32'(expCode), 32'(gotCode));
        repeat (holdCycles) begin
            @(posedge clk);
            #1;
            checkValue(testName, "ack held", 32'd1, {31'd0, ack});
            checkValue(testName, "rdata held", expData, rdata);
            checkValue(testName, "excCode held", 32'(expCode), 32'(excCode));
        end
        req = 1'b0;
        @(posedge clk);
        #1;
        checkValue(testName, "ack release", 32'd0, {31'd0, ack});
    endtask

    task automatic pickDmAddr(output logic [31:0] a);
        logic [31:0] r;
        r = $random(seed);
        a = {18'd0, r[11:0] % 12'd3072, 2'b00};
    endtask

    task automatic wordTest();
        logic [31:0] a;
        logic [31:0] data;
        for (int i = 0; i < WordPairs; i++) begin
            pickDmAddr(a);
            data = $random(seed);
            access("word", a, memAccessPkg::widthWord, 1'b1, data, 0);
            access("word", a, memAccessPkg::widthWord, 1'b0, 32'd0, 0);
            checkValue("word", "readback", data, rdata);
        end
    endtask

    task automatic subwordTest();
        logic [31:0] base;
        logic [31:0] data;
        pickDmAddr(base);
        for (int off = 0; off < 4; off++) begin
            data = $random(seed);
            // Alternate the sign bit so both extensions occur
            data[7] = off[0];
            access("byte", base + off, memAccessPkg::widthByte, 1'b1, data, 0);
            access("byte", base, memAccessPkg::widthWord, 1'b0, 32'd0, 0);
            access("byte", base + off, memAccessPkg::widthByte, 1'b0, 32'd0, 0);
        end
        for (int off = 0; off < 4; off += 2) begin
            data = $random(seed);
            data[15] = off[1];
            access("half", base + off, memAccessPkg::widthHalf, 1'b1, data, 0);
            access("half", base, memAccessPkg::widthWord, 1'b0, 32'd0, 0);
            access("half", base + off, memAccessPkg::widthHalf, 1'b0, 32'd0, 0);
        end
    endtask

    task automatic misalignTest();
        logic [31:0] base;
        pickDmAddr(base);
        for (int off = 1; off < 4; off++) begin
            access("misaligned", base + off, memAccessPkg::widthWord, 1'b0, 32'd0, 0);
            access("misaligned", base + off, memAccessPkg::widthWord, 1'b1, $random(seed), 0);
            access("misaligned", base, memAccessPkg::widthWord, 1'b0, 32'd0, 0);
            if (off[0]) begin
                access("misaligned", base + off, memAccessPkg::widthHalf, 1'b0, 32'd0, 0);
                access("misaligned", base + off, memAccessPkg::widthHalf, 1'b1, $random(seed), 0);
                access("misaligned", base, memAccessPkg::widthWord, 1'b0, 32'd0, 0);
            end
        end
    endtask

    task automatic regionTest();
        logic [31:0] t0;
        logic [31:0] t1;
        t0 = memAccessPkg::DefTimer0Base;
        t1 = memAccessPkg::DefTimer1Base;
        access("region", t0, memAccessPkg::widthWord, 1'b1, 32'h0000_0009, 0);
        access("region", t0, memAccessPkg::widthWord, 1'b0, 32'd0, 0);
        access("region", t1, memAccessPkg::widthWord, 1'b1, 32'h0000_000B, 0);
        access("region", t1, memAccessPkg::widthWord, 1'b0, 32'd0, 0);
        // Count register is read-only
        access("region", t0 + 32'd8, memAccessPkg::widthWord, 1'b1, 32'h1234_5678, 0);
        access("region", t0 + 32'd8, memAccessPkg::widthWord, 1'b0, 32'd0, 0);
        access("region", t1 + 32'd8, memAccessPkg::widthWord, 1'b1, 32'h8765_4321, 0);
        access("region", t1 + 32'd8, memAccessPkg::widthWord, 1'b0, 32'd0, 0);
        access("region", t0 + 32'd4, memAccessPkg::widthHalf, 1'b0, 32'd0, 0);
        access("region", t0 + 32'd4, memAccessPkg::widthHalf, 1'b1, 32'h0000_BEEF, 0);
        access("region", t1 + 32'd1, memAccessPkg::widthByte, 1'b0, 32'd0, 0);
        access("region", t1 + 32'd1, memAccessPkg::widthByte, 1'b1, 32'h0000_00A5, 0);
        access("region", 32'h0000_7F20, memAccessPkg::widthWord, 1'b1, 32'hCAFE_0001, 0);
        access("region", 32'h0000_7F20, memAccessPkg::widthWord, 1'b0, 32'd0, 0);
        access("region", 32'h0000_7F30, memAccessPkg::widthWord, 1'b0, 32'd0, 0);
        access("region", 32'h0000_7F30, memAccessPkg::widthWord, 1'b1, 32'hDEAD_0002, 0);
        access("region", 32'h0000_5000, memAccessPkg::widthWord, 1'b0, 32'd0, 0);
        access("region", 32'h0000_5000, memAccessPkg::widthWord, 1'b1, 32'hDEAD_0003, 0);
    endtask

    task automatic handshakeTest();
        logic [31:0] a;
        pickDmAddr(a);
        access("handshake", a, memAccessPkg::widthWord, 1'b1, $random(seed), 6);
        access("handshake", a, memAccessPkg::widthWord, 1'b0, 32'd0, 0);
        access("handshake", a + 32'd3, memAccessPkg::widthByte, 1'b0, 32'd0, 3);
    endtask

    initial begin
        repeat (AccessCount * 10 + 200) @(posedge clk);
        $display("Checks failed");
        $fatal(1, "Timeout, the DUT stopped answering requests");
    end

    initial begin
        rst = 1'b1;
        req = 1'b0;
        addr = 32'd0;
        width = memAccessPkg::widthWord;
        write = 1'b0;
        wdata = 32'd0;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = fillWord(i);
            shadow[i] = fillWord(i);
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        checkValue("reset", "ack", 32'd0, {31'd0, ack});
        checkValue("reset", "memByteen", 32'd0, {28'd0, memByteen});
        checkValue("reset", "excCode", 32'd0, 32'(excCode));
        checkValue("reset", "rdata", 32'd0, rdata);
        wordTest();
        subwordTest();
        misalignTest();
        regionTest();
        handshakeTest();
        $display("All checks passed");
        $finish;
    end

endmodule

//--- verif/memAccessTb_sva.sv
module memAccessTbSva (
    input logic                  clk,
    input logic                  rst,
    input logic                  req,
    input logic                  ack,
    input logic                  write,
    input logic [3:0]            memByteen,
    input memAccessPkg::excCodeT excCode
);

    // Ack is released only after req goes low
    ackHeld: assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack)
        else $error("ack fell while req was still high");

    ackRise: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
        else $error("ack rose without a pending request");

    // Write enables come from an accepted store
    byteenSource: assert property (@(posedge clk) disable iff (rst)
        (memByteen != 4'b0000) |-> $past(req && write && !ack))
        else $error("byte enables active without a store request");

    byteenSingle: assert property (@(posedge clk) disable iff (rst)
        (memByteen != 4'b0000) |=> (memByteen == 4'b0000))
        else $error("byte enables active for more than one cycle");

    // Store that wrote memory must end without an exception
    byteenLegal: assert property (@(posedge clk) disable iff (rst)
        (memByteen != 4'b0000) |-> ##2 (excCode == memAccessPkg::excNone))
        else $error("memory written by an access that raised an exception");

endmodule
